//--- design/rename_cfg_pkg.sv
package rename_cfg_pkg;

    // ============================================================
    // register file sizes
    // ============================================================

    // architectural registers seen by software
    localparam int unsigned ARCH_REGS = 32;

    // physical registers in the PRF
    localparam int unsigned PHYS_REGS = 64;

    // registers not holding committed state start out free
    localparam int unsigned FREE_DEPTH = PHYS_REGS - ARCH_REGS;

    // ============================================================
    // index widths
    // ============================================================

    localparam int unsigned PHYS_IDX_W = $clog2(PHYS_REGS);
    localparam int unsigned ARCH_IDX_W = $clog2(ARCH_REGS);

    // pointer into the free-list storage, wraps on its own
    localparam int unsigned FREE_PTR_W = $clog2(FREE_DEPTH);

    // count needs one more bit to hold FREE_DEPTH itself
    localparam int unsigned FREE_CNT_W = $clog2(FREE_DEPTH + 1);

    // ============================================================
    // index types
    // ============================================================

    typedef logic [PHYS_IDX_W-1:0] phys_reg_t;
    typedef logic [ARCH_IDX_W-1:0] arch_reg_t;
    typedef logic [FREE_PTR_W-1:0] free_ptr_t;
    typedef logic [FREE_CNT_W-1:0] free_count_t;

endpackage

//--- design/uop_pkg.sv
package uop_pkg;

    // ============================================================
    // operation kinds entering rename
    // ============================================================

    // 2-bit encoding, matches the decode field
    typedef enum logic [1:0] {
        UOP_ALU    = 2'd0,
        UOP_LOAD   = 2'd1,
        UOP_STORE  = 2'd2,
        UOP_BRANCH = 2'd3
    } uop_kind_e;

    // ============================================================
    // destination rule
    // ============================================================

    // alu and load produce a register result
    // store and branch never write the register file
    // dest 0 is filtered separately by the rename stage
    function automatic logic writes_dest(input uop_kind_e kind);
        logic result;
        case (kind)
            UOP_ALU:    result = 1'b1;
            UOP_LOAD:   result = 1'b1;
            UOP_STORE:  result = 1'b0;
            UOP_BRANCH: result = 1'b0;
            default:    result = 1'b0;
        endcase
        return result;
    endfunction

endpackage

//--- design/free_list_if.sv
`timescale 1ns/1ps

// allocate side of the free list
interface free_list_if;

    import rename_cfg_pkg::*;

    // rename wants a new physical register this cycle
    logic      alloc_req;

    // granted index, only meaningful with alloc_valid
    phys_reg_t alloc_phys;

    // combinational grant in the same cycle as the request
    logic      alloc_valid;

    // no stored entries left, a release may still be forwarded
    logic      empty;

    // rename side
    modport requester (
        output alloc_req,
        input  alloc_phys,
        input  alloc_valid,
        input  empty
    );

    // free list side
    modport provider (
        input  alloc_req,
        output alloc_phys,
        output alloc_valid,
        output empty
    );

endinterface

//--- design/free_list.sv
`timescale 1ns/1ps

module free_list (
    input  logic                        clock,
    input  logic                        reset,

    // allocate side toward rename
    free_list_if.provider               fl,

    // release side from commit
    input  logic                        commit_valid_i,
    input  rename_cfg_pkg::phys_reg_t   commit_old_phys_i,

    // number of stored free registers
    output rename_cfg_pkg::free_count_t free_count_o
);

    import rename_cfg_pkg::*;

    // ============================================================
    // storage and pointers
    // ============================================================

    phys_reg_t   fifo_q [FREE_DEPTH];
    free_ptr_t   head_q;
    free_ptr_t   tail_q;
    free_count_t count_q;

    // per-cycle decisions
    logic        rel_ok;
    logic        list_empty;
    logic        bypass;
    logic        push;
    logic        pop;
    free_count_t count_d;

    // ============================================================
    // release first
    // ============================================================

    // physical 0 is hardwired, never returned to the pool
    assign rel_ok     = commit_valid_i && (commit_old_phys_i != '0);
    assign list_empty = (count_q == '0);

    // empty list plus a release in the same cycle
    // the released index goes straight to the requester
    assign bypass = fl.alloc_req && list_empty && rel_ok;

    // a forwarded release is never written
    assign push = rel_ok && !bypass;

    // head only moves when a stored entry is handed out
    assign pop = fl.alloc_req && !list_empty;

    // ============================================================
    // allocate side
    // ============================================================

    // grant against stored count plus this cycle's release
    assign fl.alloc_valid = fl.alloc_req && (!list_empty || rel_ok);
    assign fl.empty       = list_empty;

    always_comb begin
        fl.alloc_phys = '0;
        if (fl.alloc_valid) begin
            if (list_empty) begin
                // forwarded from commit
                fl.alloc_phys = commit_old_phys_i;
            end else begin
                fl.alloc_phys = fifo_q[head_q];
            end
        end
    end

    // ============================================================
    // count update
    // ============================================================

    // +1 for accepted release, -1 for granted allocation
    // bypass does both and leaves the count alone
    always_comb begin
        count_d = count_q;
        case ({push, pop})
            2'b10:   count_d = count_q + free_count_t'(1);
            2'b01:   count_d = count_q - free_count_t'(1);
            default: count_d = count_q;
        endcase
    end

    assign free_count_o = count_q;

    // ============================================================
    // state
    // ============================================================

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            head_q  <= '0;
            // list starts full, next write slot wraps onto head
            tail_q  <= '0;
            count_q <= free_count_t'(FREE_DEPTH);
            // every register above the arch set starts free
            for (int i = 0; i < FREE_DEPTH; i++) begin
                fifo_q[i] <= phys_reg_t'(ARCH_REGS + i);
            end
        end else begin
            if (push) begin
                fifo_q[tail_q] <= commit_old_phys_i;
                tail_q         <= tail_q + free_ptr_t'(1);
            end
            if (pop) begin
                head_q <= head_q + free_ptr_t'(1);
            end
            count_q <= count_d;
        end
    end

endmodule

//--- design/map_table.sv
`timescale 1ns/1ps

module map_table (
    input  logic                      clock,
    input  logic                      reset,

    // source lookups
    input  rename_cfg_pkg::arch_reg_t src1_arch_i,
    input  rename_cfg_pkg::arch_reg_t src2_arch_i,
    output rename_cfg_pkg::phys_reg_t src1_phys_o,
    output rename_cfg_pkg::phys_reg_t src2_phys_o,

    // destination lookup and update
    input  rename_cfg_pkg::arch_reg_t dest_arch_i,
    output rename_cfg_pkg::phys_reg_t old_phys_o,
    input  logic                      write_en_i,
    input  rename_cfg_pkg::phys_reg_t write_phys_i
);

    import rename_cfg_pkg::*;

    // ============================================================
    // speculative map, one entry per arch register
    // ============================================================

    phys_reg_t map_q [ARCH_REGS];

    // entry 0 stays pinned to physical 0
    logic      write_ok;

    assign write_ok = write_en_i && (dest_arch_i != '0);

    // reads see the table before this cycle's write
    // so a source equal to its own dest gets the old mapping
    assign src1_phys_o = map_q[src1_arch_i];
    assign src2_phys_o = map_q[src2_arch_i];

    // previous mapping, released later by commit
    assign old_phys_o  = map_q[dest_arch_i];

    // ============================================================
    // update
    // ============================================================

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            // identity: arch r lives in phys r
            for (int i = 0; i < ARCH_REGS; i++) begin
                map_q[i] <= phys_reg_t'(i);
            end
        end else begin
            if (write_ok) begin
                map_q[dest_arch_i] <= write_phys_i;
            end
        end
    end

endmodule

//--- design/rename_stage.sv
`timescale 1ns/1ps

module rename_stage (
    // dispatch side
    input  logic                      disp_valid_i,
    input  uop_pkg::uop_kind_e        disp_kind_i,
    input  rename_cfg_pkg::arch_reg_t disp_dest_i,

    // rename results
    output logic                      ren_valid_o,
    output logic                      ren_stall_o,
    output rename_cfg_pkg::phys_reg_t ren_dest_phys_o,
    output rename_cfg_pkg::phys_reg_t ren_old_phys_o,

    // free list allocate side
    free_list_if.requester            fl,

    // map table destination port
    output logic                      map_write_en_o,
    output rename_cfg_pkg::phys_reg_t map_write_phys_o,
    input  rename_cfg_pkg::phys_reg_t map_old_phys_i
);

    import rename_cfg_pkg::*;
    import uop_pkg::*;

    // ============================================================
    // allocation decision
    // ============================================================

    // instruction needs a fresh physical register
    logic needs_dest;

    // request granted this cycle
    logic granted;

    // arch 0 is never renamed
    assign needs_dest = disp_valid_i
                     && writes_dest(disp_kind_i)
                     && (disp_dest_i != '0);

    assign fl.alloc_req = needs_dest;

    assign granted = needs_dest && fl.alloc_valid;

    // only a drained list with no release to forward refuses
    assign ren_stall_o = needs_dest && fl.empty && !fl.alloc_valid;

    // instructions without a dest pass straight through
    assign ren_valid_o = disp_valid_i && !ren_stall_o;

    // ============================================================
    // map update and outputs
    // ============================================================

    // no map change while stalled
    assign map_write_en_o   = granted;
    assign map_write_phys_o = fl.alloc_phys;

    // zero for store, branch, dest 0 and stall
    always_comb begin
        ren_dest_phys_o = '0;
        ren_old_phys_o  = '0;
        if (granted) begin
            ren_dest_phys_o = fl.alloc_phys;
            // previous mapping goes to commit for release
            ren_old_phys_o  = map_old_phys_i;
        end
    end

endmodule

//--- design/rename_top.sv
`timescale 1ns/1ps

module rename_top (
    input  logic                        clock,
    input  logic                        reset,

    // dispatch
    input  logic                        disp_valid_i,
    input  uop_pkg::uop_kind_e          disp_kind_i,
    input  rename_cfg_pkg::arch_reg_t   disp_dest_i,
    input  rename_cfg_pkg::arch_reg_t   disp_src1_i,
    input  rename_cfg_pkg::arch_reg_t   disp_src2_i,

    // rename results
    output logic                        ren_valid_o,
    output logic                        ren_stall_o,
    output rename_cfg_pkg::phys_reg_t   ren_dest_phys_o,
    output rename_cfg_pkg::phys_reg_t   ren_old_phys_o,
    output rename_cfg_pkg::phys_reg_t   ren_src1_phys_o,
    output rename_cfg_pkg::phys_reg_t   ren_src2_phys_o,

    // commit release
    input  logic                        commit_valid_i,
    input  rename_cfg_pkg::phys_reg_t   commit_old_phys_i,
    output rename_cfg_pkg::free_count_t free_count_o
);

    import rename_cfg_pkg::*;

    // ============================================================
    // internal wiring
    // ============================================================

    free_list_if fl_if ();

    // stage <-> map destination port
    logic      map_write_en;
    phys_reg_t map_write_phys;
    phys_reg_t map_old_phys;

    // ============================================================
    // instances
    // ============================================================

    rename_stage u_rename_stage (
        .disp_valid_i     (disp_valid_i),
        .disp_kind_i      (disp_kind_i),
        .disp_dest_i      (disp_dest_i),
        .ren_valid_o      (ren_valid_o),
        .ren_stall_o      (ren_stall_o),
        .ren_dest_phys_o  (ren_dest_phys_o),
        .ren_old_phys_o   (ren_old_phys_o),
        .fl               (fl_if.requester),
        .map_write_en_o   (map_write_en),
        .map_write_phys_o (map_write_phys),
        .map_old_phys_i   (map_old_phys)
    );

    map_table u_map_table (
        .clock        (clock),
        .reset        (reset),
        .src1_arch_i  (disp_src1_i),
        .src2_arch_i  (disp_src2_i),
        .src1_phys_o  (ren_src1_phys_o),
        .src2_phys_o  (ren_src2_phys_o),
        .dest_arch_i  (disp_dest_i),
        .old_phys_o   (map_old_phys),
        .write_en_i   (map_write_en),
        .write_phys_i (map_write_phys)
    );

    free_list u_free_list (
        .clock             (clock),
        .reset             (reset),
        .fl                (fl_if.provider),
        .commit_valid_i    (commit_valid_i),
        .commit_old_phys_i (commit_old_phys_i),
        .free_count_o      (free_count_o)
    );

endmodule

//--- sim/tb_rename_top.sv
`timescale 1ns/1ps

module tb_rename_top;

    import rename_cfg_pkg::*;
    import uop_pkg::*;

    // ============================================================
    // dut signals
    // ============================================================

    logic        clock;
    logic        reset;
    logic        disp_valid_i;
    uop_kind_e   disp_kind_i;
    arch_reg_t   disp_dest_i;
    arch_reg_t   disp_src1_i;
    arch_reg_t   disp_src2_i;
    logic        ren_valid_o;
    logic        ren_stall_o;
    phys_reg_t   ren_dest_phys_o;
    phys_reg_t   ren_old_phys_o;
    phys_reg_t   ren_src1_phys_o;
    phys_reg_t   ren_src2_phys_o;
    logic        commit_valid_i;
    phys_reg_t   commit_old_phys_i;
    free_count_t free_count_o;

    // reference model state
    phys_reg_t   model_free_q [$];
    phys_reg_t   model_map [ARCH_REGS];
    // old mappings handed out and not yet committed
    phys_reg_t   pending_q [$];

    int          errors;
    int          checks;
    int          test_errors;
    int          tests_run;
    int          tests_failed;
    int          wait_cnt;
    int          held_cnt;
    int          n_alloc;
    integer      seed;
    logic [31:0] r;
    logic        held;
    logic        v;
    logic        cv;
    uop_kind_e   k;
    arch_reg_t   d;
    arch_reg_t   s1;
    arch_reg_t   s2;
    phys_reg_t   p;
    phys_reg_t   m;
    phys_reg_t   cp;
    free_count_t cnt;

    rename_top u_rename_top (.*);

    initial begin
        clock = 1'b0;
        forever #5 clock = ~clock;
    end

    // hard stop in case a test loop goes wrong
    initial begin : watchdog
        repeat (20000) @(posedge clock);
        $display("simulation did not finish within the cycle limit");
        $display("sim failed");
        $finish;
    end

    // ============================================================
    // helpers
    // ============================================================

    task automatic expect_eq(input string what, input logic [31:0] got,
                             input logic [31:0] exp);
        checks++;
        assert (got === exp)
        else begin
            $display("MISMATCH at %0t: %s got %0d expected %0d", $time, what, got, exp);
            errors++;
        end
    endtask

    // one cycle of stimulus, returns once outputs and model are settled
    task automatic drive(input logic dv, input uop_kind_e dk, input arch_reg_t dd,
                         input arch_reg_t ds1, input arch_reg_t ds2,
                         input logic c_v, input phys_reg_t c_p);
        @(posedge clock);
        disp_valid_i      <= dv;
        disp_kind_i       <= dk;
        disp_dest_i       <= dd;
        disp_src1_i       <= ds1;
        disp_src2_i       <= ds2;
        commit_valid_i    <= c_v;
        commit_old_phys_i <= c_p;
        @(negedge clock);
        // model runs at the negedge, step past it
        #1;
    endtask

    task automatic end_test(input string name);
        tests_run++;
        if (errors == test_errors) begin
            $display("test %0d %s: ok", tests_run, name);
        end else begin
            tests_failed++;
            $display("test %0d %s: %0d errors", tests_run, name, errors - test_errors);
        end
        test_errors = errors;
    endtask

    // ============================================================
    // reference model and per-cycle checks
    // ============================================================

    always @(negedge clock) begin : model_check
        logic      needs;
        logic      rel;
        logic      grant;
        logic      bypass;
        phys_reg_t g;
        if (reset) begin
            model_free_q.delete();
            pending_q.delete();
            for (int i = 0; i < FREE_DEPTH; i++) begin
                model_free_q.push_back(phys_reg_t'(ARCH_REGS + i));
            end
            for (int i = 0; i < ARCH_REGS; i++) begin
                model_map[i] = phys_reg_t'(i);
            end
        end else begin
            // alu and load write a dest, arch 0 is never renamed
            needs  = disp_valid_i && (disp_kind_i == UOP_ALU || disp_kind_i == UOP_LOAD)
                  && (disp_dest_i != 0);
            rel    = commit_valid_i && (commit_old_phys_i != 0);
            grant  = 1'b0;
            bypass = 1'b0;
            g      = '0;
            if (needs && model_free_q.size() != 0) begin
                grant = 1'b1;
                g     = model_free_q[0];
            end else if (needs && rel) begin
                // empty list, release forwarded
                grant  = 1'b1;
                bypass = 1'b1;
                g      = commit_old_phys_i;
            end
            expect_eq("free_count_o", free_count_o, model_free_q.size());
            expect_eq("ren_stall_o", ren_stall_o, needs && !grant);
            expect_eq("ren_valid_o", ren_valid_o, disp_valid_i && !(needs && !grant));
            expect_eq("ren_dest_phys_o", ren_dest_phys_o, grant ? g : 0);
            expect_eq("ren_old_phys_o", ren_old_phys_o, grant ? model_map[disp_dest_i] : 0);
            expect_eq("ren_src1_phys_o", ren_src1_phys_o, model_map[disp_src1_i]);
            expect_eq("ren_src2_phys_o", ren_src2_phys_o, model_map[disp_src2_i]);
            // state after the coming edge
            if (grant && !bypass) begin
                void'(model_free_q.pop_front());
            end
            if (rel && !bypass) begin
                model_free_q.push_back(commit_old_phys_i);
            end
            if (grant) begin
                pending_q.push_back(model_map[disp_dest_i]);
                model_map[disp_dest_i] = g;
            end
        end
    end

    // ============================================================
    // tests
    // ============================================================

    initial begin
        disp_valid_i      = 1'b0;
        disp_kind_i       = UOP_ALU;
        disp_dest_i       = '0;
        disp_src1_i       = '0;
        disp_src2_i       = '0;
        commit_valid_i    = 1'b0;
        commit_old_phys_i = '0;
        errors            = 0;
        checks            = 0;
        test_errors       = 0;
        tests_run         = 0;
        tests_failed      = 0;
        seed              = 32'he3c3_7818;
        reset             = 1'b1;
        repeat (4) @(posedge clock);
        reset <= 1'b0;
        wait_cnt = 0;
        while (reset === 1'b1 && wait_cnt < 10) begin
            @(negedge clock);
            wait_cnt++;
        end
        if (reset !== 1'b0) begin
            $display("reset never released");
            errors++;
        end

        // reset state, then allocations in fifo order
        drive(1'b0, UOP_ALU, 0, 0, 0, 1'b0, 0);
        expect_eq("count after reset", free_count_o, FREE_DEPTH);
        expect_eq("valid after reset", ren_valid_o, 0);
        expect_eq("stall after reset", ren_stall_o, 0);
        for (int i = 1; i <= 4; i++) begin
            drive(1'b1, UOP_ALU, arch_reg_t'(i), 0, 0, 1'b0, 0);
            expect_eq("first allocations", ren_dest_phys_o, ARCH_REGS + i - 1);
            expect_eq("identity old mapping", ren_old_phys_o, i);
        end
        end_test("reset state");

        // source sees new mapping, own dest as source sees the old one
        drive(1'b1, UOP_ALU, 5, 0, 0, 1'b0, 0);
        // fifth allocation since reset
        p = phys_reg_t'(ARCH_REGS + 4);
        drive(1'b1, UOP_LOAD, 6, 5, 5, 1'b0, 0);
        expect_eq("source after rename", ren_src1_phys_o, p);
        drive(1'b1, UOP_ALU, 5, 5, 0, 1'b0, 0);
        expect_eq("source equal to dest", ren_src1_phys_o, p);
        expect_eq("old mapping of dest", ren_old_phys_o, p);
        end_test("map forwarding");

        // store, branch, alu to r0, load to r0
        drive(1'b0, UOP_ALU, 0, 0, 0, 1'b0, 0);
        cnt = free_count_o;
        for (int i = 0; i < 5; i++) begin
            k = (i == 0) ? UOP_STORE : (i == 1) ? UOP_BRANCH : (i == 2) ? UOP_ALU : UOP_LOAD;
            d = (i < 2) ? arch_reg_t'(9) : arch_reg_t'(0);
            drive(i < 4, k, d, 0, 0, 1'b0, 0);
            expect_eq("count without allocation", free_count_o, cnt);
            if (i < 4) begin
                expect_eq("valid without allocation", ren_valid_o, 1);
                expect_eq("dest without allocation", ren_dest_phys_o, 0);
                expect_eq("old without allocation", ren_old_phys_o, 0);
            end
        end
        end_test("no allocation");

        // drain the list, then hold a stalled alu
        n_alloc = free_count_o;
        for (int i = 0; i < n_alloc; i++) begin
            r = $random(seed);
            drive(1'b1, UOP_ALU, arch_reg_t'(1 + (r % 31)), 0, 0, 1'b0, 0);
        end
        drive(1'b0, UOP_ALU, 0, 0, 0, 1'b0, 0);
        expect_eq("count when drained", free_count_o, 0);
        drive(1'b1, UOP_ALU, 3, 3, 0, 1'b0, 0);
        expect_eq("stall when drained", ren_stall_o, 1);
        expect_eq("valid when drained", ren_valid_o, 0);
        m = ren_src1_phys_o;
        repeat (2) begin
            drive(1'b1, UOP_ALU, 3, 3, 0, 1'b0, 0);
            expect_eq("stall held", ren_stall_o, 1);
            expect_eq("map held during stall", ren_src1_phys_o, m);
        end
        end_test("exhaustion");

        // release of phys 0 does not help
        drive(1'b1, UOP_ALU, 3, 3, 0, 1'b1, 0);
        expect_eq("stall with release of 0", ren_stall_o, 1);
        p = pending_q.pop_front();
        wait_cnt = 0;
        drive(1'b1, UOP_ALU, 3, 3, 0, 1'b1, p);
        // count here is the state after the release of 0
        expect_eq("count with release of 0", free_count_o, 0);
        while (ren_stall_o && wait_cnt < 8) begin
            drive(1'b1, UOP_ALU, 3, 3, 0, 1'b0, 0);
            wait_cnt++;
        end
        if (ren_stall_o) begin
            $display("stall never dropped after the same-cycle release");
            errors++;
        end
        expect_eq("bypassed index", ren_dest_phys_o, p);
        drive(1'b0, UOP_ALU, 0, 0, 0, 1'b0, 0);
        expect_eq("count after bypass", free_count_o, 0);
        end_test("release-first bypass");

        // random mix, sparse commits first so the list runs dry
        held     = 1'b0;
        held_cnt = 0;
        for (int i = 0; i < 400; i++) begin
            if (!held) begin
                r  = $random(seed);
                v  = r[0] | r[1];
                k  = uop_kind_e'(r[3:2]);
                d  = r[8:4];
                s1 = r[13:9];
                s2 = r[18:14];
            end
            cv = 1'b0;
            cp = '0;
            if (pending_q.size() != 0 && (held || ((i < 200) ? (r[21:20] == 0) : r[20]))) begin
                cv = 1'b1;
                cp = pending_q.pop_front();
            end
            drive(v, k, d, s1, s2, cv, cp);
            held     = ren_stall_o;
            held_cnt = held ? held_cnt + 1 : 0;
            if (held_cnt > 8) begin
                $display("instruction stuck in stall during the random mix");
                errors++;
                break;
            end
        end
        drive(1'b0, UOP_ALU, 0, 0, 0, 1'b0, 0);
        end_test("random mix");

        $display("tests %0d, failed %0d, checks %0d, errors %0d",
                 tests_run, tests_failed, checks, errors);
        if (errors == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

//--- list.f
design/rename_cfg_pkg.sv
design/uop_pkg.sv
design/free_list_if.sv
design/free_list.sv
design/map_table.sv
design/rename_stage.sv
design/rename_top.sv
sim/tb_rename_top.sv

//--- Bender.yml
package:
  name: rename

sources:
  - files:
      - design/rename_cfg_pkg.sv
      - design/uop_pkg.sv
      - design/free_list_if.sv
      - design/free_list.sv
      - design/map_table.sv
      - design/rename_stage.sv
      - design/rename_top.sv
  - target: simulation
    files:
      - sim/tb_rename_top.sv
